/* mem_access_top.f */
mem_access_pkg.sv
mem_bus_if.sv
uncached_port.sv
write_through_cache.sv
access_router.sv
mem_access_top.sv
tb_mem_access.sv

/* Makefile */
TOP = tb_mem_access

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module mem_access_top -f mem_access_top.f

sim:
	verilator --binary --top-module $(TOP) -f mem_access_top.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

/* tb_mem_access.sv */
`timescale 1ns/10ps

module tb_mem_access;
    import mem_access_pkg::*;

    localparam int timeout_cycles = 64;
    localparam int num_requests   = 2000;

    logic        clk;
    logic        rstn;
    logic        pipe_valid;
    access_op_e  pipe_op;
    logic [31:0] pipe_addr;
    logic [31:0] pipe_wdata;
    logic [3:0]  pipe_wstrb;
    logic        pipe_done;
    logic [31:0] pipe_rdata;
    logic        mem_req;
    logic        mem_wr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
    logic        mem_addr_ok;
    logic        mem_data_ok;
    logic [31:0] mem_rdata;

    // responder memory indexed by addr[9:2]
    logic [31:0] mem [256];

    // reference model memory and cache mirror
    logic [31:0]          model_mem [256];
    logic [15:0]          m_valid;
    logic [tag_width-1:0] m_tag  [16];
    logic [31:0]          m_data [16];

    logic [31:0] lfsr_q;

    mem_access_top dut_i (
        .clk         (clk),
        .rstn        (rstn),
        .pipe_valid  (pipe_valid),
        .pipe_op     (pipe_op),
        .pipe_addr   (pipe_addr),
        .pipe_wdata  (pipe_wdata),
        .pipe_wstrb  (pipe_wstrb),
        .pipe_done   (pipe_done),
        .pipe_rdata  (pipe_rdata),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////

    // x^32 + x^22 + x^2 + x + 1 in right-shift form
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input logic [7:0] w);
        return {~w, w ^ 8'h3c, w + 8'h5a, w};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] wd,
                                                input logic [3:0]  strb);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                r[8*b +: 8] = wd[8*b +: 8];
            end
        end
        return r;
    endfunction

    task automatic end_with_failure();
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s expected 0x%h actual 0x%h",
                     $time, name, expected, actual);
            end_with_failure();
        end
    endtask

    ////////////////////
    // one request
    ////////////////////

    task automatic run_request();
        logic [1:0]  op_bits;
        logic        unc;
        logic        route_unc;
        logic [31:0] addr;
        logic [3:0]  idx;
        logic [7:0]  widx;
        logic        hit;
        logic        no_traffic;
        logic [31:0] exp_rdata;
        int          addr_wait;
        int          data_wait;
        int          data_delay;
        int          cycles;
        int          addr_count;
        logic        req_seen;
        logic        read_pending;
        logic        done_seen;

        op_bits = 2'(take_bits(2));
        unc = (take_bits(2) == 32'd0);
        addr = {(unc ? uncached_region : 4'h0), 20'h0, 6'(take_bits(6)), 2'b00};
        case (op_bits)
            2'd2:    pipe_op = op_store;
            2'd3:    pipe_op = op_inval;
            default: pipe_op = op_load;
        endcase
        pipe_addr  = addr;
        pipe_wstrb = 4'(take_bits(4));
        pipe_wdata = take_bits(32);
        addr_wait  = int'(take_bits(2));
        data_delay = int'(take_bits(2));

        idx = addr[5:2];
        widx = addr[9:2];
        route_unc = unc && (pipe_op != op_inval);
        hit = !route_unc && m_valid[idx] && (m_tag[idx] == addr[31:6]);
        no_traffic = (pipe_op == op_inval) || (pipe_op == op_load && hit);

        pipe_valid = 1'b1;
        cycles = 0;
        addr_count = 0;
        data_wait = 0;
        req_seen = 1'b0;
        read_pending = 1'b0;
        done_seen = 1'b0;

        while (!done_seen) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("timeout: no pipe_done within %0d cycles", timeout_cycles);
                end_with_failure();
            end
            // memory responder
            mem_data_ok = 1'b0;
            if (mem_req) begin
                req_seen = 1'b1;
            end
            if (mem_addr_ok) begin
                // taken at the last rising edge
                mem_addr_ok = 1'b0;
            end else if (mem_req) begin
                if (addr_wait == 0) begin
                    mem_addr_ok = 1'b1;
                    addr_count++;
                    check_value("mem_wr", 32'(pipe_op == op_store), 32'(mem_wr));
                    check_value("mem_addr", addr, mem_addr);
                    if (mem_wr) begin
                        check_value("mem_wdata", pipe_wdata, mem_wdata);
                        check_value("mem_wstrb", 32'(pipe_wstrb), 32'(mem_wstrb));
                        mem[mem_addr[9:2]] = merge_bytes(mem[mem_addr[9:2]], mem_wdata,
                                                         mem_wstrb);
                    end else begin
                        read_pending = 1'b1;
                        data_wait = data_delay;
                    end
                end else begin
                    addr_wait--;
                end
            end
            if (read_pending && !mem_addr_ok) begin
                if (data_wait == 0) begin
                    mem_data_ok = 1'b1;
                    mem_rdata = mem[addr[9:2]];
                    read_pending = 1'b0;
                end else begin
                    data_wait--;
                end
            end
            done_seen = pipe_done;
        end

        // response checks
        if (no_traffic) begin
            check_value("mem_req", 32'd0, 32'(req_seen));
            check_value("pipe_done latency", 32'd2, cycles);
        end else begin
            check_value("memory accesses", 32'd1, addr_count);
        end

        // model update
        case (pipe_op)
            op_load: begin
                if (hit) begin
                    exp_rdata = m_data[idx];
                end else begin
                    exp_rdata = model_mem[widx];
                end
                check_value("pipe_rdata", exp_rdata, pipe_rdata);
                if (!route_unc && !hit) begin
                    m_valid[idx] = 1'b1;
                    m_tag[idx]   = addr[31:6];
                    m_data[idx]  = model_mem[widx];
                end
            end
            op_store: begin
                model_mem[widx] = merge_bytes(model_mem[widx], pipe_wdata, pipe_wstrb);
                // no write-allocate
                if (hit) begin
                    m_data[idx] = merge_bytes(m_data[idx], pipe_wdata, pipe_wstrb);
                end
            end
            default: begin
                m_valid[idx] = 1'b0;
            end
        endcase

        // request held through the done cycle, next one follows after it
        @(negedge clk);
        pipe_valid = 1'b0;
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        lfsr_q      = 32'hc1f5;
        rstn        = 1'b0;
        pipe_valid  = 1'b0;
        pipe_op     = op_load;
        pipe_addr   = '0;
        pipe_wdata  = '0;
        pipe_wstrb  = '0;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        m_valid     = '0;
        for (int i = 0; i < 256; i++) begin
            mem[8'(i)]       = fill_word(8'(i));
            model_mem[8'(i)] = fill_word(8'(i));
        end

        repeat (10) @(negedge clk);
        rstn = 1'b1;

        // quiet until the first request
        repeat (4) begin
            @(negedge clk);
            check_value("pipe_done", 32'd0, 32'(pipe_done));
            check_value("mem_req", 32'd0, 32'(mem_req));
        end

        for (int n = 0; n < num_requests; n++) begin
            run_request();
        end

        $display("Regression passed");
        $finish;
    end

endmodule

/* mem_access_top.sv */
`timescale 1ns/10ps

module mem_access_top (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       pipe_valid,
    input  mem_access_pkg::access_op_e pipe_op,
    input  logic [31:0]                pipe_addr,
    input  logic [31:0]                pipe_wdata,
    input  logic [3:0]                 pipe_wstrb,
    output logic                       pipe_done,
    output logic [31:0]                pipe_rdata,
    output logic                       mem_req,
    output logic                       mem_wr,
    output logic [31:0]                mem_addr,
    output logic [31:0]                mem_wdata,
    output logic [3:0]                 mem_wstrb,
    input  logic                       mem_addr_ok,
    input  logic                       mem_data_ok,
    input  logic [31:0]                mem_rdata
);
    import mem_access_pkg::*;

    logic        cache_start;
    logic        cache_done;
    logic [31:0] cache_rdata;
    logic        unc_start;
    logic        unc_done;
    logic [31:0] unc_rdata;
    logic        unc_wr;

    mem_bus_if cache_bus ();
    mem_bus_if unc_bus ();

    // the uncached port never sees op_inval
    assign unc_wr = (pipe_op == op_store);

    write_through_cache cache_i (
        .clk   (clk),
        .rstn  (rstn),
        .start (cache_start),
        .op    (pipe_op),
        .addr  (pipe_addr),
        .wdata (pipe_wdata),
        .wstrb (pipe_wstrb),
        .done  (cache_done),
        .rdata (cache_rdata),
        .bus   (cache_bus.master)
    );

    uncached_port unc_i (
        .clk   (clk),
        .rstn  (rstn),
        .start (unc_start),
        .wr    (unc_wr),
        .addr  (pipe_addr),
        .wdata (pipe_wdata),
        .wstrb (pipe_wstrb),
        .done  (unc_done),
        .rdata (unc_rdata),
        .bus   (unc_bus.master)
    );

    access_router router_i (
        .clk         (clk),
        .rstn        (rstn),
        .pipe_valid  (pipe_valid),
        .pipe_op     (pipe_op),
        .pipe_addr   (pipe_addr),
        .pipe_done   (pipe_done),
        .pipe_rdata  (pipe_rdata),
        .cache_start (cache_start),
        .unc_start   (unc_start),
        .cache_done  (cache_done),
        .cache_rdata (cache_rdata),
        .unc_done    (unc_done),
        .unc_rdata   (unc_rdata),
        .cache_bus   (cache_bus.slave),
        .unc_bus     (unc_bus.slave),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

endmodule

/* access_router.sv */
`timescale 1ns/10ps

module access_router (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       pipe_valid,
    input  mem_access_pkg::access_op_e pipe_op,
    input  logic [31:0]                pipe_addr,
    output logic                       pipe_done,
    output logic [31:0]                pipe_rdata,
    output logic                       cache_start,
    output logic                       unc_start,
    input  logic                       cache_done,
    input  logic [31:0]                cache_rdata,
    input  logic                       unc_done,
    input  logic [31:0]                unc_rdata,
    mem_bus_if.slave                   cache_bus,
    mem_bus_if.slave                   unc_bus,
    output logic                       mem_req,
    output logic                       mem_wr,
    output logic [31:0]                mem_addr,
    output logic [31:0]                mem_wdata,
    output logic [3:0]                 mem_wstrb,
    input  logic                       mem_addr_ok,
    input  logic                       mem_data_ok,
    input  logic [31:0]                mem_rdata
);
    import mem_access_pkg::*;

    logic busy_q;
    logic owner_unc_q;
    logic accept;
    logic route_unc;

    ////////////////////
    // dispatch
    ////////////////////

    assign accept = pipe_valid && !busy_q;
    // invalidate always goes to the cache, whatever the region
    assign route_unc = (pipe_addr[31:28] == uncached_region) && (pipe_op != op_inval);

    assign cache_start = accept && !route_unc;
    assign unc_start   = accept && route_unc;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy_q      <= 1'b0;
            owner_unc_q <= 1'b0;
        end else if (accept) begin
            busy_q      <= 1'b1;
            owner_unc_q <= route_unc;
        end else if (pipe_done) begin
            busy_q <= 1'b0;
        end
    end

    assign pipe_done  = owner_unc_q ? unc_done : cache_done;
    assign pipe_rdata = owner_unc_q ? unc_rdata : cache_rdata;

    ////////////////////
    // memory port
    ////////////////////

    always_comb begin
        if (owner_unc_q) begin
            mem_req   = unc_bus.req;
            mem_wr    = unc_bus.wr;
            mem_addr  = unc_bus.addr;
            mem_wdata = unc_bus.wdata;
            mem_wstrb = unc_bus.wstrb;
        end else begin
            mem_req   = cache_bus.req;
            mem_wr    = cache_bus.wr;
            mem_addr  = cache_bus.addr;
            mem_wdata = cache_bus.wdata;
            mem_wstrb = cache_bus.wstrb;
        end
    end

    // acknowledges reach the owner only
    assign cache_bus.addr_ok = !owner_unc_q && mem_addr_ok;
    assign cache_bus.data_ok = !owner_unc_q && mem_data_ok;
    assign cache_bus.rdata   = mem_rdata;
    assign unc_bus.addr_ok   = owner_unc_q && mem_addr_ok;
    assign unc_bus.data_ok   = owner_unc_q && mem_data_ok;
    assign unc_bus.rdata     = mem_rdata;

endmodule

/* write_through_cache.sv */
`timescale 1ns/10ps

module write_through_cache (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     start,
    input  mem_access_pkg::access_op_e op,
    input  logic [31:0]              addr,
    input  logic [31:0]              wdata,
    input  logic [3:0]               wstrb,
    output logic                     done,
    output logic [31:0]              rdata,
    mem_bus_if.master                bus
);
    import mem_access_pkg::*;

    localparam int lines = 1 << index_width;

    path_state_e state, next_state;

    logic [lines-1:0]     valid_q;
    logic [tag_width-1:0] tag_arr  [lines];
    logic [31:0]          data_arr [lines];
    logic [31:0]          rdata_q;

    logic [index_width-1:0] idx;
    logic [tag_width-1:0]   tag;
    logic                   hit;
    logic                   fill;
    logic                   merge;
    logic                   inval;

    ////////////////////
    // lookup
    ////////////////////

    assign idx = addr[offset_width +: index_width];
    assign tag = addr[31 -: tag_width];
    assign hit = valid_q[idx] && (tag_arr[idx] == tag);

    // miss refill lands with data_ok
    assign fill  = (state == st_data) && bus.data_ok;
    // store hit merges when memory takes the write
    assign merge = (state == st_addr) && (op == op_store) && hit && bus.addr_ok;
    assign inval = (state == st_addr) && (op == op_inval);

    ////////////////////
    // control
    ////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (start) begin
                    next_state = st_addr;
                end
            end
            st_addr: begin
                case (op)
                    op_inval: next_state = st_done;
                    op_store: begin
                        if (bus.addr_ok) begin
                            next_state = st_done;
                        end
                    end
                    default: begin
                        if (hit) begin
                            next_state = st_done;
                        end else if (bus.addr_ok) begin
                            next_state = st_data;
                        end
                    end
                endcase
            end
            st_data: begin
                if (bus.data_ok) begin
                    next_state = st_done;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (inval) begin
            valid_q[idx] <= 1'b0;
        end else if (fill) begin
            valid_q[idx] <= 1'b1;
        end
    end

    ////////////////////
    // arrays
    ////////////////////

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_arr[idx]  <= tag;
            data_arr[idx] <= bus.rdata;
        end else if (merge) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    data_arr[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_addr && op == op_load && hit) begin
            rdata_q <= data_arr[idx];
        end else if (fill) begin
            rdata_q <= bus.rdata;
        end
    end

    // memory is only asked for stores and load misses
    assign bus.req   = (state == st_addr) && ((op == op_store) || (op == op_load && !hit));
    assign bus.wr    = (op == op_store);
    assign bus.addr  = addr;
    assign bus.wdata = wdata;
    assign bus.wstrb = wstrb;

    assign done  = (state == st_done);
    assign rdata = rdata_q;

endmodule

/* uncached_port.sv */
`timescale 1ns/10ps

module uncached_port (
    input  logic        clk,
    input  logic        rstn,
    input  logic        start,
    input  logic        wr,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    output logic        done,
    output logic [31:0] rdata,
    mem_bus_if.master   bus
);
    import mem_access_pkg::*;

    path_state_e state, next_state;
    logic [31:0] rdata_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (start) begin
                    next_state = st_addr;
                end
            end
            st_addr: begin
                // a write is finished once the address is taken
                if (bus.addr_ok) begin
                    next_state = wr ? st_done : st_data;
                end
            end
            st_data: begin
                if (bus.data_ok) begin
                    next_state = st_done;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // read word captured with data_ok
    always_ff @(posedge clk) begin
        if (state == st_data && bus.data_ok) begin
            rdata_q <= bus.rdata;
        end
    end

    // request fields come straight from the pipeline, which holds them
    assign bus.req   = (state == st_addr);
    assign bus.wr    = wr;
    assign bus.addr  = addr;
    assign bus.wdata = wdata;
    assign bus.wstrb = wstrb;

    assign done  = (state == st_done);
    assign rdata = rdata_q;

endmodule

/* mem_bus_if.sv */
`timescale 1ns/10ps

interface mem_bus_if;

    // request side, held until addr_ok
    logic        req;
    logic        wr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;

    // response side
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] rdata;

    // path end
    modport master (
        output req, wr, addr, wdata, wstrb,
        input  addr_ok, data_ok, rdata
    );

    // router end
    modport slave (
        input  req, wr, addr, wdata, wstrb,
        output addr_ok, data_ok, rdata
    );

endinterface

/* mem_access_pkg.sv */
package mem_access_pkg;

    ////////////////////
    // operation codes
    ////////////////////

    // cache maintenance rides on the same request channel as load/store
    typedef enum logic [1:0] {
        op_load  = 2'd0,
        op_store = 2'd1,
        op_inval = 2'd2
    } access_op_e;

    // shared by the cache and the uncached port
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_addr = 2'd1,
        st_data = 2'd2,
        st_done = 2'd3
    } path_state_e;

    ////////////////////
    // address split
    ////////////////////

    // byte offset inside a one-word line
    localparam int offset_width = 2;
    // 16 lines
    localparam int index_width  = 4;
    // addr[31:6]
    localparam int tag_width    = 32 - index_width - offset_width;

    // addr[31:28] value that bypasses the cache
    localparam logic [3:0] uncached_region = 4'ha;

endpackage
